/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module tb_rack -f list.f -o Vtb_rack

run: compile
	-./obj_dir/Vtb_rack > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* afferent_scaler.sv */
module afferent_scaler (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     i_sim_reset,
    input  rack_pkg::param_word_u    i_ia_gain,
    input  rack_pkg::param_word_u    i_ii_gain,
    input  rack_pkg::afferent_pair_t i_rate,
    input  logic                     i_rate_valid,
    output logic                     o_rate_ready,
    output rack_pkg::current_pair_t  o_current,
    output logic                     o_current_valid,
    input  logic                     i_current_ready
);
    import rack_pkg::*;

    // stage one product: unbiased exponent (signed) and 24-bit mantissa with hidden one
    typedef struct packed {
        logic        sign;
        logic [9:0]  exp;
        logic [23:0] mant;
    } prod_t;

    prod_t         s1_ia;
    prod_t         s1_ii;
    logic          s1_valid;
    logic          s1_ready;
    current_pair_t s2_current;
    logic          s2_valid;
    logic          s2_ready;

    // float multiply, truncated, normals and zero only
    function automatic prod_t fmul(float_t a, float_t b);
        logic [47:0] m;
        prod_t       p;
        m = {1'b1, a.mant} * {1'b1, b.mant};
        p.sign = a.sign ^ b.sign;
        if (a.exp == 8'd0 || b.exp == 8'd0)
        begin
            // zero mantissa makes the conversion yield zero
            p.exp  = '0;
            p.mant = '0;
        end
        else
        begin
            // product in [1,4), one step of normalize
            p.exp  = {2'b00, a.exp} + {2'b00, b.exp} - 10'd254 + {9'd0, m[47]};
            p.mant = m[47] ? m[47:24] : m[46:23];
        end
        return p;
    endfunction

    // float to integer toward zero, then to fixed point
    function automatic logic signed [word_w-1:0] to_fixed(prod_t p);
        logic [word_w-1:0]        mag;
        logic signed [word_w-1:0] int_val;
        mag = '0;
        if ($signed(p.exp) >= 10'sd31)
        begin
            // out of range, clamp
            int_val = p.sign ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
        end
        else
        begin
            if (p.exp[9])
            begin
                // magnitude below one
                mag = '0;
            end
            else if (p.exp[4:0] <= 5'd23)
            begin
                mag = {8'd0, p.mant} >> (5'd23 - p.exp[4:0]);
            end
            else
            begin
                mag = {8'd0, p.mant} << (p.exp[4:0] - 5'd23);
            end
            int_val = p.sign ? -$signed(mag) : $signed(mag);
        end
        // wraps on overflow like the integer shift it replaces
        return int_val <<< frac_shift;
    endfunction

    // ready chain, a stage can take data when empty or when it empties now
    assign s2_ready     = !s2_valid || i_current_ready;
    assign s1_ready     = !s1_valid || s2_ready;
    // no intake during a sim reset, so nothing is swallowed by the flush
    assign o_rate_ready = s1_ready && !i_sim_reset;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else if (i_sim_reset)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else
        begin
            if (s1_ready)
            begin
                s1_valid <= i_rate_valid;
            end
            if (s2_ready)
            begin
                s2_valid <= s1_valid;
            end
        end
    end

    // payload, gains sampled at acceptance
    always_ff @(posedge ep50trig)
    begin
        if (i_rate_valid && o_rate_ready)
        begin
            s1_ia <= fmul(i_rate.ia, i_ia_gain.f);
            s1_ii <= fmul(i_rate.ii, i_ii_gain.f);
        end
        if (s1_valid && s2_ready)
        begin
            s2_current.ia <= to_fixed(s1_ia);
            s2_current.ii <= to_fixed(s1_ii);
        end
    end

    assign o_current       = s2_current;
    assign o_current_valid = s2_valid;

endmodule

/* list.f */
rack_pkg.sv
param_bank.sv
sim_timebase.sv
afferent_scaler.sv
spike_tally.sv
status_readout.sv
rack_top.sv
rack_assertions.sv
tb_rack.sv

/* param_bank.sv */
module param_bank (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic [rack_pkg::trig_w-1:0] i_trigger,
    input  rack_pkg::param_word_u       i_wire_data,
    output rack_pkg::param_set_t        o_params
);
    import rack_pkg::*;

    // each word loads on its own strobe bit
    // several strobes in one cycle all take the same data word

    // Ia afferent gain, float
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_params.ia_gain <= ia_gain_default;
        end
        else if (i_trigger[trig_ia_gain])
        begin
            o_params.ia_gain <= i_wire_data;
        end
    end

    // II afferent gain, float
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_params.ii_gain <= ii_gain_default;
        end
        else if (i_trigger[trig_ii_gain])
        begin
            o_params.ii_gain <= i_wire_data;
        end
    end

    // simulation tick divider, integer count
    // 381 runs at half real time, 762 at real time
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_params.clk_div <= clk_div_default;
        end
        else if (i_trigger[trig_clk_div])
        begin
            o_params.clk_div <= i_wire_data;
        end
    end

endmodule

/* rack_assertions.sv */
module rack_assertions (
    input logic        ep50trig,
    input logic        reset_global,
    input logic        i_flush,
    input logic        i_valid,
    input logic        i_ready,
    input logic [63:0] i_data,
    input logic        i_in_ready,
    input logic        i_tick
);

    // stalled output holds valid and data until taken
    assert property (@(posedge ep50trig) disable iff (reset_global || i_flush)
        (i_valid && !i_ready) |=> (i_valid && $stable(i_data)))
    else $error("current stream changed while stalled");

    // empty pipeline takes a rate right after reset
    assert property (@(posedge ep50trig) $fell(reset_global) |-> i_in_ready)
    else $error("rate ready low after reset");

    // tick is a single-cycle pulse
    assert property (@(posedge ep50trig) disable iff (reset_global) i_tick |=> !i_tick)
    else $error("tick lasted two cycles");

endmodule

bind afferent_scaler rack_assertions u_scaler_checks (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .i_flush      (i_sim_reset),
    .i_valid      (o_current_valid),
    .i_ready      (i_current_ready),
    .i_data       (o_current),
    .i_in_ready   (o_rate_ready),
    .i_tick       (1'b0)
);

bind sim_timebase rack_assertions u_tick_checks (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .i_flush      (1'b0),
    .i_valid      (1'b0),
    .i_ready      (1'b1),
    .i_data       (64'd0),
    .i_in_ready   (1'b1),
    .i_tick       (o_tick)
);

/* rack_pkg.sv */
package rack_pkg;

    // word widths
    localparam int word_w = 32;
    localparam int half_w = 16;
    localparam int trig_w = 16;

    // trigger strobe bit that loads each parameter word
    localparam int trig_ia_gain = 1;
    localparam int trig_clk_div = 7;
    localparam int trig_ii_gain = 10;

    // fraction bits of a fixed-point current
    localparam int frac_shift = 6;

    // single-precision view of a word
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] mant;
    } float_t;

    // parameter word, either a float gain or an integer count
    typedef union packed {
        float_t            f;
        logic [word_w-1:0] count;
    } param_word_u;

    typedef struct packed {
        param_word_u ia_gain;
        param_word_u ii_gain;
        param_word_u clk_div;
    } param_set_t;

    // reset defaults: 1.5, 2.0 and 381 ticks (half real-time speed)
    localparam param_word_u ia_gain_default = 32'h3FC0_0000;
    localparam param_word_u ii_gain_default = 32'h4000_0000;
    localparam param_word_u clk_div_default = 32'd381;

    // afferent rates in pps, as floats
    typedef struct packed {
        float_t ia;
        float_t ii;
    } afferent_pair_t;

    typedef struct packed {
        logic signed [word_w-1:0] ia;
        logic signed [word_w-1:0] ii;
    } current_pair_t;

    typedef struct packed {
        logic ia;
        logic ii;
    } spike_pair_t;

    typedef struct packed {
        logic [word_w-1:0] ia;
        logic [word_w-1:0] ii;
    } count_pair_t;

    // readout index: bits 3:1 pick the word, bit 0 the half, bit 4 reads zero
    typedef logic [4:0] rd_addr_t;

    localparam logic [2:0] rd_word_time    = 3'd0;
    localparam logic [2:0] rd_word_ia_cnt  = 3'd1;
    localparam logic [2:0] rd_word_ii_cnt  = 3'd2;
    localparam logic [2:0] rd_word_ia_cur  = 3'd3;
    localparam logic [2:0] rd_word_ii_cur  = 3'd4;
    localparam logic [2:0] rd_word_ia_gain = 3'd5;
    localparam logic [2:0] rd_word_ii_gain = 3'd6;
    localparam logic [2:0] rd_word_clk_div = 3'd7;

endpackage

/* rack_top.sv */
module rack_top (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic [rack_pkg::trig_w-1:0] i_trigger,
    input  rack_pkg::param_word_u       i_wire_data,
    input  logic                        i_ext_reset,
    input  rack_pkg::afferent_pair_t    i_rate,
    input  logic                        i_rate_valid,
    output logic                        o_rate_ready,
    output rack_pkg::current_pair_t     o_current,
    output logic                        o_current_valid,
    input  logic                        i_current_ready,
    input  rack_pkg::spike_pair_t       i_spike,
    input  rack_pkg::rd_addr_t          i_rd_addr,
    output logic [rack_pkg::half_w-1:0] o_rd_data
);
    import rack_pkg::*;

    param_set_t        params;
    logic              tick;
    logic [word_w-1:0] time_tag;
    logic              sim_reset;
    count_pair_t       counts;
    // output transfer completes this edge
    logic              current_taken;

    assign current_taken = o_current_valid & i_current_ready;

    param_bank u_param_bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trigger    (i_trigger),
        .i_wire_data  (i_wire_data),
        .o_params     (params)
    );

    sim_timebase u_sim_timebase (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_clk_div    (params.clk_div),
        .i_ext_reset  (i_ext_reset),
        .o_tick       (tick),
        .o_time       (time_tag),
        .o_sim_reset  (sim_reset)
    );

    // rate stream in, fixed-point current stream out
    afferent_scaler u_afferent_scaler (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .i_sim_reset     (sim_reset),
        .i_ia_gain       (params.ia_gain),
        .i_ii_gain       (params.ii_gain),
        .i_rate          (i_rate),
        .i_rate_valid    (i_rate_valid),
        .o_rate_ready    (o_rate_ready),
        .o_current       (o_current),
        .o_current_valid (o_current_valid),
        .i_current_ready (i_current_ready)
    );

    spike_tally u_spike_tally (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (sim_reset),
        .i_tick       (tick),
        .i_spike      (i_spike),
        .o_counts     (counts)
    );

    status_readout u_status_readout (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .i_sim_reset     (sim_reset),
        .i_time          (time_tag),
        .i_counts        (counts),
        .i_params        (params),
        .i_current       (o_current),
        .i_current_taken (current_taken),
        .i_rd_addr       (i_rd_addr),
        .o_rd_data       (o_rd_data)
    );

endmodule

/* rack_trace.txt */
# columns: test op a b c d, values in hex
# Z lo hi zero | E addr half | L trig data | P stall% | R ia ii exp_ia exp_ii | D | T n | S ia ii | X n
1 Z 0 9
1 E 0a 0000
1 E 0b 3fc0
1 E 0c 0000
1 E 0d 4000
1 E 0e 017d
1 E 0f 0000
1 E 1f 0000
2 P 28
2 R 42c80000 42c80000 00002580 00003200
2 R 00000000 00000000 00000000 00000000
2 R 41280000 41280000 000003c0 00000540
2 R 3f000000 3f000000 00000000 00000040
2 R 4f32d05e 4f32d05e ffffffc0 ffffffc0
2 R c1a00000 c1a00000 fffff880 fffff600
2 D
2 P 0
2 E 06 f880
2 E 07 ffff
2 E 08 f600
2 E 09 ffff
3 L 0002 40400000
3 E 0b 4040
3 E 0d 4000
3 E 0e 017d
3 L 0480 00000009
3 E 0a 0000
3 E 0b 4040
3 E 0c 0009
3 E 0d 0000
3 E 0e 0009
3 E 0f 0000
4 T 5
4 T 8
5 S 3 5
5 S 0 2
5 E 03 0000
5 E 05 0000
6 X 15
6 Z 2 9
6 E 0b 4040
6 E 0e 0009

/* sim_timebase.sv */
module sim_timebase (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  rack_pkg::param_word_u       i_clk_div,
    input  logic                        i_ext_reset,
    output logic                        o_tick,
    output logic [rack_pkg::word_w-1:0] o_time,
    output logic                        o_sim_reset
);
    import rack_pkg::*;

    logic [word_w-1:0] div_cnt;
    // two-flop synchronizer on the external reset pin
    logic [1:0]        ext_sync;

    // down-counter, tick on zero, period is divider + 1 cycles
    // the time tag moves on the same edge so it reads one higher during the tick
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            // first period runs on the default count
            div_cnt <= clk_div_default.count;
            o_tick  <= 1'b0;
            o_time  <= '0;
        end
        else if (div_cnt == '0)
        begin
            // new divider word only taken here
            div_cnt <= i_clk_div.count;
            o_tick  <= 1'b1;
            o_time  <= o_time + 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt - 1'b1;
            o_tick  <= 1'b0;
        end
    end

    // external reset held only on tick boundaries, so whole periods
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            ext_sync    <= '0;
            o_sim_reset <= 1'b0;
        end
        else
        begin
            ext_sync <= {ext_sync[0], i_ext_reset};
            if (o_tick)
            begin
                o_sim_reset <= ext_sync[1];
            end
        end
    end

endmodule

/* spike_tally.sv */
module spike_tally (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  i_sim_reset,
    input  logic                  i_tick,
    input  rack_pkg::spike_pair_t i_spike,
    output rack_pkg::count_pair_t o_counts
);
    import rack_pkg::*;

    // spikes seen so far in the open period
    count_pair_t run;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            run      <= '0;
            o_counts <= '0;
        end
        else if (i_sim_reset)
        begin
            // sim reset drops both the open and the closed tally
            run      <= '0;
            o_counts <= '0;
        end
        else if (i_tick)
        begin
            // spike in the tick cycle still belongs to the closing period
            o_counts.ia <= run.ia + word_w'(i_spike.ia);
            o_counts.ii <= run.ii + word_w'(i_spike.ii);
            run         <= '0;
        end
        else
        begin
            run.ia <= run.ia + word_w'(i_spike.ia);
            run.ii <= run.ii + word_w'(i_spike.ii);
        end
    end

endmodule

/* status_readout.sv */
module status_readout (
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        i_sim_reset,
    input  logic [rack_pkg::word_w-1:0] i_time,
    input  rack_pkg::count_pair_t       i_counts,
    input  rack_pkg::param_set_t        i_params,
    input  rack_pkg::current_pair_t     i_current,
    input  logic                        i_current_taken,
    input  rack_pkg::rd_addr_t          i_rd_addr,
    output logic [rack_pkg::half_w-1:0] o_rd_data
);
    import rack_pkg::*;

    // currents of the last completed output transfer
    current_pair_t     last_current;
    logic [word_w-1:0] rd_word;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            last_current <= '0;
        end
        else if (i_sim_reset)
        begin
            last_current <= '0;
        end
        else if (i_current_taken)
        begin
            last_current <= i_current;
        end
    end

    // word select, upper half of the index space reads zero
    always_comb
    begin
        rd_word = '0;
        if (!i_rd_addr[4])
        begin
            case (i_rd_addr[3:1])
                rd_word_time:    rd_word = i_time;
                rd_word_ia_cnt:  rd_word = i_counts.ia;
                rd_word_ii_cnt:  rd_word = i_counts.ii;
                rd_word_ia_cur:  rd_word = last_current.ia;
                rd_word_ii_cur:  rd_word = last_current.ii;
                rd_word_ia_gain: rd_word = i_params.ia_gain.count;
                rd_word_ii_gain: rd_word = i_params.ii_gain.count;
                rd_word_clk_div: rd_word = i_params.clk_div.count;
                default:         rd_word = '0;
            endcase
        end
    end

    // even index gives the low half, one cycle behind the address
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_rd_data <= '0;
        end
        else
        begin
            o_rd_data <= i_rd_addr[0] ? rd_word[word_w-1:half_w] : rd_word[half_w-1:0];
        end
    end

endmodule

/* tb_rack.sv */
module tb_rack;
    import rack_pkg::*;

    logic                ep50trig;
    logic                reset_global;
    logic [trig_w-1:0]   i_trigger;
    param_word_u         i_wire_data;
    logic                i_ext_reset;
    afferent_pair_t      i_rate;
    logic                i_rate_valid;
    logic                o_rate_ready;
    current_pair_t       o_current;
    logic                o_current_valid;
    logic                i_current_ready;
    spike_pair_t         i_spike;
    rd_addr_t            i_rd_addr;
    logic [half_w-1:0]   o_rd_data;

    // expected current pairs in send order
    logic [63:0]         exp_q[$];
    // trace records without comment lines
    string               lines[$];
    int                  errors;
    // percent of cycles with the current stream stalled
    int                  stall_pct;
    int                  limit_cycles;

    rack_top u_rack_top (.*);

    initial
    begin
        ep50trig = 1'b0;
        forever
        begin
            #2 ep50trig = ~ep50trig;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got == exp)
        else
        begin
            $display("Fail at %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // all stimulus tasks start and end just after a rising edge
    task automatic read_half(input rd_addr_t addr, output logic [15:0] val);
        i_rd_addr = addr;
        @(posedge ep50trig);
        #1;
        val = o_rd_data;
    endtask

    // poll the low half of the time tag until it moves
    task automatic wait_time_change();
        logic [15:0] v0;
        i_rd_addr = 5'd0;
        @(posedge ep50trig);
        #1;
        v0 = o_rd_data;
        while (o_rd_data == v0)
        begin
            @(posedge ep50trig);
            #1;
        end
    endtask

    // one strobe cycle with the data word on the wire
    task automatic load_word(input logic [31:0] trig, input logic [31:0] data);
        i_trigger   = trig[trig_w-1:0];
        i_wire_data = data;
        @(posedge ep50trig);
        #1;
        i_trigger = '0;
    endtask

    // hold the rate pair until the scaler takes it
    task automatic send_rate(input logic [31:0] ia, input logic [31:0] ii);
        logic taken;
        i_rate       = {ia, ii};
        i_rate_valid = 1'b1;
        taken        = 1'b0;
        while (!taken)
        begin
            #2;
            taken = o_rate_ready;
            @(posedge ep50trig);
            #1;
        end
        i_rate_valid = 1'b0;
    endtask

    task automatic drain_stream();
        while (exp_q.size() != 0)
        begin
            @(posedge ep50trig);
            #1;
        end
    endtask

    // time tag over n periods of 10 cycles with one tick of slack
    task automatic time_periods(input int n);
        logic [15:0] t0;
        int          diff;
        wait_time_change();
        t0 = o_rd_data;
        repeat (10 * n) @(posedge ep50trig);
        #1;
        diff = int'(o_rd_data - t0);
        assert (diff >= n - 1 && diff <= n + 1)
        else
        begin
            $display("Fail at %0t: time tag moved %0d over %0d periods", $time, diff, n);
            errors++;
        end
    endtask

    // spikes in the first five cycles of one whole period
    task automatic spike_period(input int nia, input int nii);
        logic [15:0] v;
        int          cnt_ia;
        int          cnt_ii;
        int          k;
        cnt_ia = 0;
        cnt_ii = 0;
        wait_time_change();
        for (k = 0; k < 5; k++)
        begin
            i_spike.ia = (k < nia);
            i_spike.ii = (k < nii);
            cnt_ia += int'(i_spike.ia);
            cnt_ii += int'(i_spike.ii);
            @(posedge ep50trig);
            #1;
        end
        i_spike = '0;
        // wait for the closing tick and read the counts of that period
        wait_time_change();
        read_half(5'd2, v);
        check_value({16'd0, v}, cnt_ia, "Ia count");
        read_half(5'd4, v);
        check_value({16'd0, v}, cnt_ii, "II count");
    endtask

    task automatic ext_reset_hold(input int cycles);
        logic [15:0] t0;
        logic [15:0] t1;
        logic [15:0] v;
        read_half(5'd0, t0);
        // spikes all through the hold would fill the tallies if nothing cleared them
        i_ext_reset = 1'b1;
        i_spike     = '1;
        repeat (cycles) @(posedge ep50trig);
        #1;
        i_ext_reset = 1'b0;
        i_spike     = '0;
        // sim reset still runs here so both tallies read empty
        read_half(5'd2, v);
        check_value({16'd0, v}, 32'd0, "Ia count in sim reset");
        read_half(5'd4, v);
        check_value({16'd0, v}, 32'd0, "II count in sim reset");
        repeat (30) @(posedge ep50trig);
        #1;
        read_half(5'd0, t1);
        // time tag keeps running through the sim reset
        assert (t1 > t0)
        else
        begin
            $display("Fail at %0t: time tag went from %h to %h", $time, t0, t1);
            errors++;
        end
    endtask

    // back-pressure on the current stream
    initial
    begin
        void'($urandom(20345));
        forever
        begin
            @(posedge ep50trig);
            #1;
            i_current_ready = (stall_pct == 0) || (($urandom % 100) >= stall_pct);
        end
    end

    // output monitor samples late in the cycle
    initial
    begin
        logic [63:0] exp;
        forever
        begin
            @(posedge ep50trig);
            #3;
            if (!reset_global && o_current_valid && i_current_ready)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    $display("unexpected current pair %h at %0t", o_current, $time);
                    errors++;
                end
                if (exp_q.size() != 0)
                begin
                    exp = exp_q.pop_front();
                    check_value(o_current.ia, exp[63:32], "Ia current");
                    check_value(o_current.ii, exp[31:0], "II current");
                end
            end
        end
    end

    // watchdog sized from the number of trace records
    initial
    begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge ep50trig);
        $display("timeout: run did not end within %0d cycles", limit_cycles);
        $display("tests failed");
        $finish;
    end

    initial
    begin
        int          fd;
        int          n;
        int          test;
        int          cur_test;
        int          mark;
        int          tests_run;
        int          tests_bad;
        int          i;
        int          z;
        string       line;
        string       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [15:0] v;

        reset_global    = 1'b1;
        i_trigger       = '0;
        i_wire_data     = '0;
        i_ext_reset     = 1'b0;
        i_rate          = '0;
        i_rate_valid    = 1'b0;
        i_current_ready = 1'b1;
        i_spike         = '0;
        i_rd_addr       = '0;
        errors          = 0;
        stall_pct       = 0;
        limit_cycles    = 0;
        tests_run       = 0;
        tests_bad       = 0;
        cur_test        = -1;
        mark            = 0;

        fd = $fopen("rack_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open rack_trace.txt");
            errors++;
        end
        else
        begin
            // keep every non-empty line that is not a comment
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != 8'h23)
                begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        limit_cycles = 200 * lines.size() + 20;

        repeat (10) @(posedge ep50trig);
        #1;
        reset_global = 1'b0;

        for (i = 0; i < lines.size(); i++)
        begin
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            n = $sscanf(lines[i], "%d %s %h %h %h %h", test, op, a, b, c, d);
            // a new test number closes the previous test
            if (test != cur_test)
            begin
                if (cur_test >= 0)
                begin
                    $display("test %0d finished with %0d errors", cur_test, errors - mark);
                    tests_run++;
                    tests_bad += (errors != mark) ? 1 : 0;
                end
                cur_test = test;
                mark     = errors;
            end
            case (op)
                "Z":
                begin
                    for (z = int'(a); z <= int'(b); z++)
                    begin
                        read_half(rd_addr_t'(z), v);
                        check_value({16'd0, v}, 32'd0, $sformatf("readout %0d", z));
                    end
                end
                "E":
                begin
                    read_half(a[4:0], v);
                    check_value({16'd0, v}, b, $sformatf("readout %0d", a));
                end
                "L": load_word(a, b);
                "P": stall_pct = int'(a);
                "R":
                begin
                    exp_q.push_back({c, d});
                    send_rate(a, b);
                end
                "D": drain_stream();
                "T": time_periods(int'(a));
                "S": spike_period(int'(a), int'(b));
                "X": ext_reset_hold(int'(a));
                default:
                begin
                    $display("unknown trace operation %s in record %0d", op, i);
                    errors++;
                end
            endcase
        end
        if (cur_test >= 0)
        begin
            $display("test %0d finished with %0d errors", cur_test, errors - mark);
            tests_run++;
            tests_bad += (errors != mark) ? 1 : 0;
        end

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_bad, errors);
        if (errors == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
